//--- rtl/ifetch_pkg.sv
`default_nettype none

package ifetch_pkg;

  // address and data width
  localparam int xlen = 32;

  // instruction cache line fill
  typedef enum logic [1:0] {
    fill_idle,
    fill_request,
    fill_read,
    fill_commit
  } fill_state_e;

  // vector table read
  typedef enum logic [1:0] {
    vf_idle,
    vf_request,
    vf_read,
    vf_done
  } vec_state_e;

  // program counter stage
  typedef enum logic [1:0] {
    pc_reset_vector,
    pc_run,
    pc_irq_vector
  } pc_state_e;

endpackage

`default_nettype wire

//--- rtl/icache_data_ram.sv
`default_nettype none

module icache_data_ram import ifetch_pkg::*; #(
  parameter int line_bits = 4,
  parameter int line_count_bits = 3
) (
  input  logic                               clk_i,
  input  logic                               write_i,
  input  logic [line_bits+line_count_bits-1:0] waddr_i,
  input  logic [xlen-1:0]                    data_i,
  input  logic [line_bits+line_count_bits-1:0] raddr_i,
  input  logic                               rd_en_i,
  output logic [xlen-1:0]                    data_o
);

  localparam int depth = 2 ** (line_bits + line_count_bits);

  logic [xlen-1:0] mem [depth];

  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // read port only moves when enabled, so a stalled output keeps its word
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      data_o <= mem[raddr_i];
    end
  end

endmodule

`default_nettype wire

//--- rtl/icache.sv
`default_nettype none

module icache import ifetch_pkg::*; #(
  parameter int line_bits = 4,
  parameter int line_count_bits = 3
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            req_valid_i,
  input  logic [xlen-1:0] req_pc_i,
  output logic            req_ready_o,
  output logic            instr_valid_o,
  output logic [xlen-1:0] instr_o,
  output logic [xlen-1:0] instr_pc_o,
  input  logic            instr_ready_i,
  output logic            bus_req_o,
  input  logic            bus_gnt_i,
  output logic            bus_stb_o,
  output logic [xlen-3:0] bus_adr_o,
  input  logic [xlen-1:0] bus_dat_i,
  input  logic            bus_ack_i,
  output logic            empty_o
);

  localparam int tag_bits = xlen - 2 - line_bits;
  localparam int line_count = 2 ** line_count_bits;
  localparam int addr_bits = line_bits + line_count_bits;

  fill_state_e fill_state;

  logic [tag_bits-1:0]        tags [line_count];
  logic [line_count-1:0]      line_valid;
  logic [line_count_bits-1:0] victim;
  logic [tag_bits-1:0]        fill_tag;
  logic [line_bits-1:0]       word_idx;

  logic [tag_bits-1:0]        req_tag;
  logic                       hit;
  logic [line_count_bits-1:0] hit_line;
  logic                       advance;
  logic                       accept;
  logic                       miss_start;
  logic                       fill_ack;
  logic [addr_bits-1:0]       ram_waddr;
  logic [addr_bits-1:0]       ram_raddr;

  assign req_tag = req_pc_i[xlen-1:line_bits+2];

  // compare against every valid line at once
  always_comb begin
    hit = 1'b0;
    hit_line = '0;
    for (int i = 0; i < line_count; i++) begin
      if (line_valid[i] && (tags[i] == req_tag)) begin
        hit = 1'b1;
        hit_line = line_count_bits'(i);
      end
    end
  end

  // output register empties or moves on
  assign advance = ~instr_valid_o | instr_ready_i;

  assign req_ready_o = hit & advance & (fill_state == fill_idle);
  assign accept = req_valid_i & req_ready_o;
  assign miss_start = (fill_state == fill_idle) & req_valid_i & ~hit;
  assign fill_ack = (fill_state == fill_read) & bus_gnt_i & bus_ack_i;

  assign empty_o = ~instr_valid_o & (fill_state == fill_idle);

  assign bus_req_o = (fill_state == fill_request) | (fill_state == fill_read);
  assign bus_stb_o = (fill_state == fill_read);
  assign bus_adr_o = {fill_tag, word_idx};

  assign ram_waddr = {victim, word_idx};
  assign ram_raddr = {hit_line, req_pc_i[line_bits+1:2]};

  icache_data_ram #(
    .line_bits       (line_bits),
    .line_count_bits (line_count_bits)
  ) u_data_ram (
    .clk_i   (clk_i),
    .write_i (fill_ack),
    .waddr_i (ram_waddr),
    .data_i  (bus_dat_i),
    .raddr_i (ram_raddr),
    .rd_en_i (accept),
    .data_o  (instr_o)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      instr_valid_o <= 1'b0;
    end else if (advance) begin
      instr_valid_o <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_pc_o <= req_pc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_state <= fill_idle;
      line_valid <= '0;
      victim <= '0;
    end else begin
      case (fill_state)
        fill_idle: begin
          // victim stays invalid while it is being overwritten
          if (miss_start) begin
            line_valid[victim] <= 1'b0;
            fill_state <= fill_request;
          end
        end
        fill_request: begin
          if (bus_gnt_i) begin
            fill_state <= fill_read;
          end
        end
        fill_read: begin
          if (fill_ack && (word_idx == '1)) begin
            fill_state <= fill_commit;
          end
        end
        fill_commit: begin
          line_valid[victim] <= 1'b1;
          victim <= victim + 1'b1;
          fill_state <= fill_idle;
        end
        default: begin
          fill_state <= fill_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      fill_tag <= req_tag;
      word_idx <= '0;
    end else if (fill_ack) begin
      word_idx <= word_idx + 1'b1;
    end
    if (fill_state == fill_commit) begin
      tags[victim] <= fill_tag;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vector_fetch.sv
`default_nettype none

module vector_fetch import ifetch_pkg::*; #(
  parameter logic [xlen-1:0] vtable_base = '0
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  logic [xlen-1:0] offset_i,
  output logic            done_o,
  output logic [xlen-1:0] vec_pc_o,
  output logic            bus_req_o,
  input  logic            bus_gnt_i,
  output logic            bus_stb_o,
  output logic [xlen-3:0] bus_adr_o,
  input  logic [xlen-1:0] bus_dat_i,
  input  logic            bus_ack_i
);

  vec_state_e state;

  logic [xlen-3:0] entry_adr;
  logic            read_ack;

  assign read_ack = (state == vf_read) & bus_gnt_i & bus_ack_i;

  assign bus_req_o = (state == vf_request) | (state == vf_read);
  assign bus_stb_o = (state == vf_read);
  assign bus_adr_o = entry_adr;
  assign done_o = (state == vf_done);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= vf_idle;
    end else begin
      case (state)
        vf_idle: begin
          if (start_i) begin
            state <= vf_request;
          end
        end
        vf_request: begin
          if (bus_gnt_i) begin
            state <= vf_read;
          end
        end
        vf_read: begin
          if (read_ack) begin
            state <= vf_done;
          end
        end
        default: begin
          state <= vf_idle;
        end
      endcase
    end
  end

  // word address of the table entry from a byte offset
  always_ff @(posedge clk_i) begin
    if ((state == vf_idle) && start_i) begin
      entry_adr <= vtable_base[xlen-1:2] + offset_i[xlen-1:2];
    end
    if (read_ack) begin
      vec_pc_o <= bus_dat_i;
    end
  end

endmodule

`default_nettype wire

//--- rtl/bus_arbiter.sv
`default_nettype none

module bus_arbiter import ifetch_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            vec_req_i,
  input  logic            vec_stb_i,
  input  logic [xlen-3:0] vec_adr_i,
  output logic            vec_gnt_o,
  input  logic            fill_req_i,
  input  logic            fill_stb_i,
  input  logic [xlen-3:0] fill_adr_i,
  output logic            fill_gnt_o,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic [xlen-3:0] wb_adr_o
);

  // owner keeps the bus until it lets go of its request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vec_gnt_o <= 1'b0;
      fill_gnt_o <= 1'b0;
    end else if (vec_gnt_o) begin
      if (!vec_req_i) begin
        vec_gnt_o <= 1'b0;
      end
    end else if (fill_gnt_o) begin
      if (!fill_req_i) begin
        fill_gnt_o <= 1'b0;
      end
    end else if (vec_req_i) begin
      vec_gnt_o <= 1'b1;
    end else if (fill_req_i) begin
      fill_gnt_o <= 1'b1;
    end
  end

  assign wb_stb_o = (vec_gnt_o & vec_stb_i) | (fill_gnt_o & fill_stb_i);
  assign wb_adr_o = vec_gnt_o ? vec_adr_i : fill_adr_i;
  // the cycle spans exactly the strobe of the read-only master
  assign wb_cyc_o = wb_stb_o;

endmodule

`default_nettype wire

//--- rtl/pc_stage.sv
`default_nettype none

module pc_stage import ifetch_pkg::*; (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            irq_i,
  input  logic [xlen-1:0] irq_offset_i,
  output logic            irq_ack_o,
  output logic            vec_start_o,
  output logic [xlen-1:0] vec_offset_o,
  input  logic            vec_done_i,
  input  logic [xlen-1:0] vec_pc_i,
  input  logic            cache_empty_i,
  output logic            req_valid_o,
  output logic [xlen-1:0] req_pc_o,
  input  logic            req_ready_i
);

  pc_state_e state;

  logic [xlen-1:0] pc;
  logic            vec_busy;

  // pending interrupt stops issue right away
  assign req_valid_o = (state == pc_run) & ~irq_i;
  assign req_pc_o = pc;

  assign vec_start_o = (state != pc_run) & ~vec_busy;
  assign vec_offset_o = (state == pc_irq_vector) ? irq_offset_i : '0;
  assign irq_ack_o = (state == pc_irq_vector) & vec_done_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= pc_reset_vector;
      vec_busy <= 1'b0;
    end else begin
      case (state)
        pc_reset_vector, pc_irq_vector: begin
          if (vec_start_o) begin
            vec_busy <= 1'b1;
          end
          if (vec_done_i) begin
            vec_busy <= 1'b0;
            state <= pc_run;
          end
        end
        pc_run: begin
          // redirect only once nothing accepted is still in flight
          if (irq_i && cache_empty_i) begin
            state <= pc_irq_vector;
          end
        end
        default: begin
          state <= pc_reset_vector;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (vec_done_i) begin
      pc <= vec_pc_i;
    end else if (req_valid_o && req_ready_i) begin
      pc <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ifetch_top.sv
`default_nettype none

module ifetch_top import ifetch_pkg::*; #(
  parameter int line_bits = 4,
  parameter int line_count_bits = 3,
  parameter logic [xlen-1:0] vtable_base = '0
) (
  input  logic            clk_i,
  input  logic            reset_i,
  output logic            instr_valid_o,
  output logic [xlen-1:0] instr_o,
  output logic [xlen-1:0] instr_pc_o,
  input  logic            instr_ready_i,
  input  logic            irq_i,
  input  logic [xlen-1:0] irq_offset_i,
  output logic            irq_ack_o,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic [xlen-3:0] wb_adr_o,
  input  logic [xlen-1:0] wb_dat_i,
  input  logic            wb_ack_i
);

  logic            req_valid;
  logic [xlen-1:0] req_pc;
  logic            req_ready;
  logic            cache_empty;

  logic            vec_start;
  logic [xlen-1:0] vec_offset;
  logic            vec_done;
  logic [xlen-1:0] vec_pc;

  logic            vec_req;
  logic            vec_stb;
  logic [xlen-3:0] vec_adr;
  logic            vec_gnt;
  logic            fill_req;
  logic            fill_stb;
  logic [xlen-3:0] fill_adr;
  logic            fill_gnt;

  pc_stage u_pc_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .irq_i         (irq_i),
    .irq_offset_i  (irq_offset_i),
    .irq_ack_o     (irq_ack_o),
    .vec_start_o   (vec_start),
    .vec_offset_o  (vec_offset),
    .vec_done_i    (vec_done),
    .vec_pc_i      (vec_pc),
    .cache_empty_i (cache_empty),
    .req_valid_o   (req_valid),
    .req_pc_o      (req_pc),
    .req_ready_i   (req_ready)
  );

  icache #(
    .line_bits       (line_bits),
    .line_count_bits (line_count_bits)
  ) u_icache (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_valid_i   (req_valid),
    .req_pc_i      (req_pc),
    .req_ready_o   (req_ready),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .instr_ready_i (instr_ready_i),
    .bus_req_o     (fill_req),
    .bus_gnt_i     (fill_gnt),
    .bus_stb_o     (fill_stb),
    .bus_adr_o     (fill_adr),
    .bus_dat_i     (wb_dat_i),
    .bus_ack_i     (wb_ack_i),
    .empty_o       (cache_empty)
  );

  vector_fetch #(
    .vtable_base (vtable_base)
  ) u_vector_fetch (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (vec_start),
    .offset_i  (vec_offset),
    .done_o    (vec_done),
    .vec_pc_o  (vec_pc),
    .bus_req_o (vec_req),
    .bus_gnt_i (vec_gnt),
    .bus_stb_o (vec_stb),
    .bus_adr_o (vec_adr),
    .bus_dat_i (wb_dat_i),
    .bus_ack_i (wb_ack_i)
  );

  // read data and ack fan out to both masters, grant qualifies them
  bus_arbiter u_bus_arbiter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .vec_req_i  (vec_req),
    .vec_stb_i  (vec_stb),
    .vec_adr_i  (vec_adr),
    .vec_gnt_o  (vec_gnt),
    .fill_req_i (fill_req),
    .fill_stb_i (fill_stb),
    .fill_adr_i (fill_adr),
    .fill_gnt_o (fill_gnt),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o)
  );

endmodule

`default_nettype wire

//--- testbench/wb_mem_model.sv
`default_nettype none

module wb_mem_model (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic [29:0] adr_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  logic [15:0] lfsr;
  logic [15:0] lfsr_a;
  logic [15:0] lfsr_b;
  logic [1:0]  delay;
  logic [1:0]  wait_cnt;

  // 16 bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // vector table in the first 16 words and the address pattern elsewhere
  function automatic logic [31:0] word_at(input logic [29:0] adr);
    logic [31:0] a;
    a = {adr, 2'b00};
    if (a < 32'd64) begin
      return 32'h0000_1000 + 32'h0000_0400 * {28'd0, a[5:2]};
    end
    return a ^ 32'hA5A5_0000;
  endfunction

  assign lfsr_a = lfsr_next(lfsr);
  assign lfsr_b = lfsr_next(lfsr_a);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_o <= 1'b0;
      dat_o <= '0;
      wait_cnt <= '0;
      delay <= '0;
      lfsr <= 16'd7637;
    end else if (ack_o) begin
      // next delay takes one lfsr bit per step
      ack_o <= 1'b0;
      wait_cnt <= '0;
      delay <= {lfsr_a[0], lfsr_b[0]};
      lfsr <= lfsr_b;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == delay) begin
        ack_o <= 1'b1;
        dat_o <= word_at(adr_i);
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/ifetch_sva.sv
`default_nettype none

module ifetch_sva (
  input logic        clk_i,
  input logic        reset_i,
  input logic        wb_stb_o,
  input logic [29:0] wb_adr_o,
  input logic        wb_ack_i,
  input logic        instr_valid_o,
  input logic [31:0] instr_o,
  input logic [31:0] instr_pc_o,
  input logic        instr_ready_i,
  input logic        irq_ack_o
);

  // strobe and address held until the slave acks
  assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)))
    else $error("wishbone strobe or address changed before ack");

  assert property (@(posedge clk_i) disable iff (reset_i)
    (instr_valid_o && !instr_ready_i) |=>
      (instr_valid_o && $stable(instr_o) && $stable(instr_pc_o)))
    else $error("stream output changed under back-pressure");

  assert property (@(posedge clk_i) disable iff (reset_i)
    irq_ack_o |=> !irq_ack_o)
    else $error("irq ack longer than one cycle");

endmodule

bind ifetch_top ifetch_sva u_sva (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .wb_stb_o      (wb_stb_o),
  .wb_adr_o      (wb_adr_o),
  .wb_ack_i      (wb_ack_i),
  .instr_valid_o (instr_valid_o),
  .instr_o       (instr_o),
  .instr_pc_o    (instr_pc_o),
  .instr_ready_i (instr_ready_i),
  .irq_ack_o     (irq_ack_o)
);

`default_nettype wire

//--- testbench/ifetch_tb.sv
`default_nettype none

module ifetch_tb import ifetch_pkg::*; ;

  localparam logic [xlen-1:0] vtable_base = 32'h0;
  localparam logic [xlen-1:0] data_mask = 32'hA5A5_0000;
  localparam int row_total = 7;
  localparam int wait_limit = 400;

  logic            clk = 1'b0;
  logic            reset;
  logic            instr_ready;
  logic            irq;
  logic [xlen-1:0] irq_offset;
  logic            instr_valid;
  logic [xlen-1:0] instr;
  logic [xlen-1:0] instr_pc;
  logic            irq_ack;
  logic            wb_cyc;
  logic            wb_stb;
  logic [xlen-3:0] wb_adr;
  logic [xlen-1:0] wb_dat;
  logic            wb_ack;

  int              errors;
  bit              timed_out;
  int              ack_count;
  int              irq_ack_count;
  logic [xlen-1:0] exp_pc;
  logic [15:0]     lfsr_q;
  logic            held_valid;
  logic [xlen-1:0] held_instr;
  logic [xlen-1:0] held_pc;

  // stimulus table
  // a negative irq offset means no interrupt
  string           row_name [row_total];
  int              row_count [row_total];
  int              row_irq [row_total];
  bit              row_lfsr [row_total];
  logic [xlen-1:0] row_new_pc [row_total];
  int              row_reads [row_total];

  ifetch_top #(
    .line_bits       (4),
    .line_count_bits (3),
    .vtable_base     (vtable_base)
  ) dut0 (
    .clk_i         (clk),
    .reset_i       (reset),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .instr_pc_o    (instr_pc),
    .instr_ready_i (instr_ready),
    .irq_i         (irq),
    .irq_offset_i  (irq_offset),
    .irq_ack_o     (irq_ack),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_adr_o      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack)
  );

  wb_mem_model u_mem (
    .clk_i   (clk),
    .reset_i (reset),
    .cyc_i   (wb_cyc),
    .stb_i   (wb_stb),
    .adr_i   (wb_adr),
    .dat_o   (wb_dat),
    .ack_o   (wb_ack)
  );

  always #20 clk = ~clk;

  always @(negedge clk) begin
    if (!reset) begin
      if (wb_ack) begin
        ack_count++;
      end
      if (irq_ack) begin
        irq_ack_count++;
      end
    end
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [xlen-1:0] table_entry(input int idx);
    return 32'h0000_1000 + 32'h0000_0400 * idx;
  endfunction

  task automatic load_table();
    row_name = '{"reset_vector", "seq_lines", "irq_first", "irq_cached",
                 "evict_walk", "evict_return", "stall_lfsr"};
    row_count = '{1, 40, 0, 4, 80, 0, 28};
    row_irq = '{-1, -1, 8, 8, -1, 0, -1};
    row_lfsr = '{0, 0, 0, 0, 0, 0, 1};
    row_new_pc = '{32'h0, 32'h0, table_entry(2), table_entry(2),
                   32'h0, table_entry(0), 32'h0};
    // vector reads plus 16 per line fill
    row_reads = '{17, 32, 17, 1, 80, 17, 16};
  endtask

  task automatic finish_run();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [xlen-1:0] exp,
                             input logic [xlen-1:0] act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_instr(input string name);
    check_value(name, exp_pc, instr_pc);
    check_value(name, exp_pc ^ data_mask, instr);
    exp_pc = exp_pc + 32'd4;
  endtask

  // drive just after the rising edge and sample at the falling edge
  task automatic step_cycle(input logic rdy, input logic irq_v,
                            input logic [xlen-1:0] off, output logic took);
    @(posedge clk);
    #2;
    instr_ready = rdy;
    irq = irq_v;
    irq_offset = off;
    @(negedge clk);
    if (held_valid) begin
      if (!instr_valid || instr !== held_instr || instr_pc !== held_pc) begin
        $display("output changed while stalled, held pc %h", held_pc);
        errors++;
      end
    end
    held_valid = instr_valid & ~rdy;
    held_instr = instr;
    held_pc = instr_pc;
    took = instr_valid & rdy;
  endtask

  task automatic consume(input string name, input int count, input bit use_lfsr);
    int   got;
    int   waited;
    logic rdy;
    logic took;
    got = 0;
    waited = 0;
    while (got < count && !timed_out) begin
      rdy = 1'b1;
      if (use_lfsr) begin
        lfsr_q = lfsr_next(lfsr_q);
        rdy = lfsr_q[0];
      end
      step_cycle(rdy, 1'b0, '0, took);
      if (took) begin
        check_instr(name);
        got++;
        waited = 0;
      end else begin
        waited++;
        if (waited > wait_limit) begin
          report_timeout({name, " instruction"});
        end
      end
    end
  endtask

  task automatic take_interrupt(input string name, input int offset,
                                input logic [xlen-1:0] new_pc);
    logic            pending;
    logic            took;
    logic            seen;
    logic            adr_seen;
    logic [xlen-3:0] adr;
    int              drained;
    int              waited;
    pending = 1'b1;
    seen = 1'b0;
    adr_seen = 1'b0;
    adr = '0;
    drained = 0;
    waited = 0;
    while (!seen && !timed_out) begin
      step_cycle(1'b1, pending, offset, took);
      if (wb_ack && !adr_seen) begin
        adr_seen = 1'b1;
        adr = wb_adr;
      end
      if (took) begin
        // items accepted before the redirect still drain out first
        if (pending) begin
          check_instr(name);
          drained++;
          if (drained > 2) begin
            $display("%s: too many instructions before the interrupt vector", name);
            errors++;
          end
        end else begin
          exp_pc = new_pc;
          check_instr(name);
          seen = 1'b1;
        end
      end
      if (irq_ack) begin
        pending = 1'b0;
      end
      waited++;
      if (waited > wait_limit) begin
        report_timeout({name, " interrupt vector"});
      end
    end
    if (!timed_out) begin
      if (!adr_seen) begin
        $display("%s: no vector table read seen on the bus", name);
        errors++;
      end else begin
        check_value({name, " vector address"}, (vtable_base + offset) >> 2,
                    {2'b00, adr});
      end
    end
  endtask

  // hold ready low until the bus has been quiet for a while
  task automatic settle();
    int   quiet;
    int   waited;
    logic took;
    quiet = 0;
    waited = 0;
    while (quiet < 16 && !timed_out) begin
      step_cycle(1'b0, 1'b0, '0, took);
      if (wb_cyc) begin
        quiet = 0;
      end else begin
        quiet++;
      end
      waited++;
      if (waited > wait_limit) begin
        report_timeout("bus idle");
      end
    end
  endtask

  initial begin
    int ack_start;
    int irq_start;
    reset = 1'b1;
    instr_ready = 1'b0;
    irq = 1'b0;
    irq_offset = '0;
    errors = 0;
    timed_out = 1'b0;
    ack_count = 0;
    irq_ack_count = 0;
    lfsr_q = 16'd7637;
    held_valid = 1'b0;
    held_instr = '0;
    held_pc = '0;
    exp_pc = table_entry(0);
    load_table();
    repeat (8) @(posedge clk);
    #2;
    // stream, irq ack and bus all idle out of reset
    check_value("reset outputs", '0, {instr_valid, irq_ack, wb_cyc, wb_stb});
    reset = 1'b0;
    for (int r = 0; r < row_total && !timed_out; r++) begin
      ack_start = ack_count;
      irq_start = irq_ack_count;
      consume(row_name[r], row_count[r], row_lfsr[r]);
      if (row_irq[r] >= 0) begin
        take_interrupt(row_name[r], row_irq[r], row_new_pc[r]);
      end
      settle();
      if (!timed_out) begin
        check_value({row_name[r], " bus reads"}, row_reads[r], ack_count - ack_start);
        check_value({row_name[r], " irq acks"}, (row_irq[r] >= 0) ? 1 : 0,
                    irq_ack_count - irq_start);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- filelist.f
rtl/ifetch_pkg.sv
rtl/icache_data_ram.sv
rtl/icache.sv
rtl/vector_fetch.sv
rtl/bus_arbiter.sv
rtl/pc_stage.sv
rtl/ifetch_top.sv
testbench/wb_mem_model.sv
testbench/ifetch_sva.sv
testbench/ifetch_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ifetch_tb \
  -f filelist.f --Mdir obj_dir -o ifetch_sim

./obj_dir/ifetch_sim > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
  exit 1
fi
exit 0
